// File: verilog/cpuPkg.sv
package cpuPkg;

    typedef logic [31:0] wordT;     // Bus, register and memory word
    typedef logic [3:0]  regIdxT;   // One of sixteen general registers

    // ALU operation codes, anything else gives a zero result
    typedef enum logic [4:0] {
        opAdd  = 5'd1,
        opSub  = 5'd2,
        opMul  = 5'd3,
        opDiv  = 5'd4,
        opShr  = 5'd5,
        opShl  = 5'd6,
        opShra = 5'd7,
        opRor  = 5'd8,
        opRol  = 5'd9,
        opAnd  = 5'd10,
        opOr   = 5'd11,
        opNeg  = 5'd12,
        opXor  = 5'd13,
        opNor  = 5'd14,
        opNot  = 5'd15
    } aluOpT;

    // Three-register layout
    typedef struct packed {
        logic [4:0]  opcode;
        regIdxT      ra;
        regIdxT      rb;
        regIdxT      rc;
        logic [14:0] unused;
    } regFormT;

    // Register plus 19-bit signed constant
    typedef struct packed {
        logic [4:0]  opcode;
        regIdxT      ra;
        regIdxT      rb;
        logic [18:0] c;
    } immFormT;

    typedef union packed {
        regFormT regForm;
        immFormT immForm;
    } instrWord;

endpackage

// File: verilog/regFile.sv
`timescale 1ns/1ns

module regFile (
    input  logic             clk,
    input  logic             reset,
    input  cpuPkg::wordT     bus,
    input  cpuPkg::instrWord ir,
    input  logic             Rin,
    input  logic             Rout,
    input  logic             BAout,
    input  logic             Gra,
    input  logic             Grb,
    input  logic             Grc,
    output cpuPkg::wordT     regOut,
    output logic             regOutValid
);
    import cpuPkg::*;

    wordT        regs [16];
    regIdxT      sel;
    logic [15:0] selOneHot;
    logic        baseZero;

    // IR field select, ra wins over rb over rc
    always_comb begin
        if (Gra) begin
            sel = ir.regForm.ra;
        end else if (Grb) begin
            sel = ir.regForm.rb;
        end else if (Grc) begin
            sel = ir.regForm.rc;
        end else begin
            sel = '0;   // Direct access means R0
        end
    end

    assign selOneHot = 16'b1 << sel;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 16; i++) begin
                if (Rin && selOneHot[i]) regs[i] <= bus;
            end
        end
    end

    // R0 acts as a zero base for address arithmetic
    assign baseZero    = BAout && (sel == '0);
    assign regOutValid = Rout || BAout;
    assign regOut      = (regOutValid && !baseZero) ? regs[sel] : '0;

endmodule

// File: verilog/alu.sv
`timescale 1ns/1ns

module alu (
    input  cpuPkg::wordT  a,
    input  cpuPkg::wordT  b,
    input  cpuPkg::aluOpT opcode,
    input  logic          incPC,
    output logic [63:0]   result
);
    import cpuPkg::*;

    logic [4:0]         shAmt;
    logic [63:0]        doubled;
    logic [63:0]        rotRight;
    logic [63:0]        rotLeft;
    logic signed [63:0] product;
    wordT               divisor;
    logic signed [31:0] quotient;
    logic signed [31:0] remainder;
    logic [63:0]        divResult;
    wordT               single;

    assign shAmt = b[4:0];  // Shift distance from B

    // Rotates fall out of shifting A concatenated with itself
    assign doubled  = {a, a};
    assign rotRight = doubled >> shAmt;
    assign rotLeft  = doubled << shAmt;

    assign product = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});

    // Keep the divider defined when B is zero
    assign divisor   = (b == '0) ? 32'd1 : b;
    assign quotient  = $signed(a) / $signed(divisor);
    assign remainder = $signed(a) % $signed(divisor);
    assign divResult = (b == '0) ? {a, 32'hFFFF_FFFF} : {remainder, quotient};

    always_comb begin
        case (opcode)
            opAdd:   single = a + b;
            opSub:   single = a - b;
            opShr:   single = a >> shAmt;
            opShl:   single = a << shAmt;
            opShra:  single = $signed(a) >>> shAmt;
            opRor:   single = rotRight[31:0];
            opRol:   single = rotLeft[63:32];
            opAnd:   single = a & b;
            opOr:    single = a | b;
            opNeg:   single = -b;      // Unary ops work on the bus side
            opXor:   single = a ^ b;
            opNor:   single = ~(a | b);
            opNot:   single = ~b;
            default: single = '0;
        endcase
    end

    // Increment overrides the opcode for PC update
    always_comb begin
        if (incPC) begin
            result = {32'b0, b + 32'd1};
        end else if (opcode == opMul) begin
            result = product;
        end else if (opcode == opDiv) begin
            result = divResult;
        end else begin
            result = {32'b0, single};
        end
    end

endmodule

// File: verilog/memoryUnit.sv
`timescale 1ns/1ns

module memoryUnit #(
    parameter int memDepth = 512
) (
    input  logic         clk,
    input  logic         reset,
    input  cpuPkg::wordT bus,
    input  logic         MARin,
    input  logic         MDRin,
    input  logic         read,
    input  logic         write,
    output cpuPkg::wordT mdr
);
    import cpuPkg::*;

    localparam int addrBits = $clog2(memDepth);

    wordT                mem [memDepth];
    wordT                mar;
    logic [addrBits-1:0] memAddr;
    wordT                memData;

    assign memAddr = mar[addrBits-1:0];  // Wraps at the memory size
    assign memData = mem[memAddr];

    always_ff @(posedge clk) begin
        if (reset) begin
            mar <= '0;
            mdr <= '0;
        end else begin
            if (MARin) mar <= bus;
            if (MDRin) begin
                mdr <= read ? memData : bus;  // Read step fetches the word
            end
        end
    end

    // Store path always comes from MDR
    always_ff @(posedge clk) begin
        if (write) mem[memAddr] <= mdr;
    end

endmodule

// File: verilog/specialRegs.sv
`timescale 1ns/1ns

module specialRegs (
    input  logic             clk,
    input  logic             reset,
    input  cpuPkg::wordT     bus,
    input  logic [63:0]      aluResult,
    input  logic             PCin,
    input  logic             IRin,
    input  logic             Yin,
    input  logic             Zin,
    input  logic             HIin,
    input  logic             LOin,
    output cpuPkg::wordT     pc,
    output cpuPkg::wordT     y,
    output cpuPkg::wordT     hi,
    output cpuPkg::wordT     lo,
    output cpuPkg::wordT     zHigh,
    output cpuPkg::wordT     zLow,
    output cpuPkg::instrWord ir
);

    always_ff @(posedge clk) begin
        if (reset) begin
            pc    <= '0;
            ir    <= '0;
            y     <= '0;
            zHigh <= '0;
            zLow  <= '0;
            hi    <= '0;
            lo    <= '0;
        end else begin
            if (PCin) pc <= bus;
            if (IRin) ir <= bus;
            if (Yin)  y  <= bus;   // Holds ALU operand A
            if (Zin) begin
                // Both halves in one step
                zHigh <= aluResult[63:32];
                zLow  <= aluResult[31:0];
            end
            if (HIin) hi <= bus;
            if (LOin) lo <= bus;
        end
    end

endmodule

// File: verilog/busUnit.sv
`timescale 1ns/1ns

module busUnit (
    input  logic             clk,
    input  logic             reset,
    input  cpuPkg::wordT     regOut,
    input  cpuPkg::wordT     pc,
    input  cpuPkg::wordT     mdr,
    input  cpuPkg::wordT     hi,
    input  cpuPkg::wordT     lo,
    input  cpuPkg::wordT     zHigh,
    input  cpuPkg::wordT     zLow,
    input  cpuPkg::instrWord ir,
    input  logic             regOutValid,
    input  logic             PCout,
    input  logic             MDRout,
    input  logic             HIout,
    input  logic             LOout,
    input  logic             ZHighOut,
    input  logic             ZLowOut,
    input  logic             InPortOut,
    input  logic             Cout,
    input  logic             InPortIn,
    input  logic             OutPortIn,
    input  cpuPkg::wordT     InPortData,
    output cpuPkg::wordT     bus,
    output cpuPkg::wordT     outPortData
);
    import cpuPkg::*;

    wordT inPortReg;
    wordT cValue;

    assign cValue = {{13{ir.immForm.c[18]}}, ir.immForm.c};  // Sign-extend C

    // Fixed priority in case a step enables more than one source
    always_comb begin
        if (regOutValid)    bus = regOut;
        else if (PCout)     bus = pc;
        else if (MDRout)    bus = mdr;
        else if (HIout)     bus = hi;
        else if (LOout)     bus = lo;
        else if (ZHighOut)  bus = zHigh;
        else if (ZLowOut)   bus = zLow;
        else if (InPortOut) bus = inPortReg;
        else if (Cout)      bus = cValue;
        else                bus = '0;   // Idle bus reads zero
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            inPortReg   <= '0;
            outPortData <= '0;
        end else begin
            if (InPortIn)  inPortReg   <= InPortData;
            if (OutPortIn) outPortData <= bus;
        end
    end

endmodule

// File: verilog/datapath.sv
`timescale 1ns/1ns

module datapath #(
    parameter int memDepth = 512
) (
    input  logic          clk,
    input  logic          reset,
    input  logic          read,
    input  logic          write,
    input  logic          BAout,
    input  logic          Rin,
    input  logic          Rout,
    input  logic          Gra,
    input  logic          Grb,
    input  logic          Grc,
    input  logic          MARin,
    input  logic          MDRin,
    input  logic          HIin,
    input  logic          LOin,
    input  logic          Yin,
    input  logic          Zin,
    input  logic          PCin,
    input  logic          IRin,
    input  logic          incPC,
    input  logic          InPortIn,
    input  logic          OutPortIn,
    input  logic          HIout,
    input  logic          LOout,
    input  logic          ZHighOut,
    input  logic          ZLowOut,
    input  logic          MDRout,
    input  logic          PCout,
    input  logic          InPortOut,
    input  logic          Cout,
    input  cpuPkg::aluOpT opcode,
    input  cpuPkg::wordT  InPortData,
    output cpuPkg::wordT  busData,
    output cpuPkg::wordT  outPortData
);
    import cpuPkg::*;

    wordT        bus;
    wordT        regOut;
    logic        regOutValid;
    wordT        pc;
    wordT        mdr;
    wordT        y;
    wordT        hi;
    wordT        lo;
    wordT        zHigh;
    wordT        zLow;
    instrWord    ir;
    logic [63:0] aluResult;

    regFile i_regFile (
        .clk(clk), .reset(reset), .bus(bus), .ir(ir),
        .Rin(Rin), .Rout(Rout), .BAout(BAout),
        .Gra(Gra), .Grb(Grb), .Grc(Grc),
        .regOut(regOut), .regOutValid(regOutValid)
    );

    // Operand A is always Y, operand B is the bus
    alu i_alu (.a(y), .b(bus), .opcode(opcode), .incPC(incPC), .result(aluResult));

    memoryUnit #(.memDepth(memDepth)) i_memoryUnit (
        .clk(clk), .reset(reset), .bus(bus),
        .MARin(MARin), .MDRin(MDRin), .read(read), .write(write),
        .mdr(mdr)
    );

    specialRegs i_specialRegs (
        .clk(clk), .reset(reset), .bus(bus), .aluResult(aluResult),
        .PCin(PCin), .IRin(IRin), .Yin(Yin), .Zin(Zin), .HIin(HIin), .LOin(LOin),
        .pc(pc), .y(y), .hi(hi), .lo(lo), .zHigh(zHigh), .zLow(zLow), .ir(ir)
    );

    busUnit i_busUnit (
        .clk(clk), .reset(reset),
        .regOut(regOut), .pc(pc), .mdr(mdr), .hi(hi), .lo(lo),
        .zHigh(zHigh), .zLow(zLow), .ir(ir),
        .regOutValid(regOutValid), .PCout(PCout), .MDRout(MDRout),
        .HIout(HIout), .LOout(LOout), .ZHighOut(ZHighOut), .ZLowOut(ZLowOut),
        .InPortOut(InPortOut), .Cout(Cout),
        .InPortIn(InPortIn), .OutPortIn(OutPortIn), .InPortData(InPortData),
        .bus(bus), .outPortData(outPortData)
    );

    assign busData = bus;   // Bus is visible for checking

endmodule

// File: bench/datapathTb.sv
`timescale 1ns/1ns

module datapathTb;
    import cpuPkg::*;

    localparam string stepFile = "bench/stepsInput.txt";

    logic        clk;
    logic        reset;
    logic [27:1] strobes;      // Same bit order as the mask column of the step file
    aluOpT       opcode;
    wordT        inPortData;
    wordT        busData;
    wordT        outPortData;
    int          cycles;
    int          cycleLimit;

    datapath #(.memDepth(512)) i_datapath (
        .clk(clk), .reset(reset),
        .read(strobes[1]), .write(strobes[2]), .BAout(strobes[3]),
        .Rin(strobes[4]), .Rout(strobes[5]),
        .Gra(strobes[6]), .Grb(strobes[7]), .Grc(strobes[8]),
        .MARin(strobes[9]), .MDRin(strobes[10]), .HIin(strobes[11]), .LOin(strobes[12]),
        .Yin(strobes[13]), .Zin(strobes[14]), .PCin(strobes[15]), .IRin(strobes[16]),
        .incPC(strobes[17]), .InPortIn(strobes[18]), .OutPortIn(strobes[19]),
        .HIout(strobes[20]), .LOout(strobes[21]),
        .ZHighOut(strobes[22]), .ZLowOut(strobes[23]),
        .MDRout(strobes[24]), .PCout(strobes[25]),
        .InPortOut(strobes[26]), .Cout(strobes[27]),
        .opcode(opcode), .InPortData(inPortData),
        .busData(busData), .outPortData(outPortData)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stopWithFailure(input string reason);
        $display("%s", reason);
        $display("=== FAIL ===");
        $fatal(1, "Run stopped");
    endtask

    task automatic checkBus(input wordT actual, input wordT expected);
        if (actual !== expected) begin
            $display("** Error at %0t ns: busData expected %h, actual %h", $time, expected, actual);
            stopWithFailure("Bus value mismatch");
        end
    endtask

    task automatic checkOutPort(input wordT actual, input wordT expected);
        if (actual !== expected) begin
            $display("** Error at %0t ns: outPortData expected %h, actual %h",
                     $time, expected, actual);
            stopWithFailure("Output port mismatch");
        end
    endtask

    // Blank lines and lines opening with a hash are not steps
    function automatic bit isStep(input string line);
        return line.len() > 1 && line.getc(0) != 8'h23;
    endfunction

    // Bounds the run in case a step never completes
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycleLimit > 0 && cycles >= cycleLimit) begin
            stopWithFailure("Timeout: the steps did not finish within the cycle limit");
        end
    end

    initial begin
        int          fd;
        int          fields;
        int          stepCount;
        string       line;
        logic [31:0] mask;
        logic [31:0] op;
        logic [31:0] data;
        logic [31:0] fill;
        logic [31:0] chkBus;
        logic [31:0] expBus;
        logic [31:0] chkOut;
        logic [31:0] expOut;

        void'($urandom(32'h2252));
        reset      = 1'b1;
        strobes    = '0;
        opcode     = aluOpT'(5'd0);
        inPortData = '0;
        cycles     = 0;
        cycleLimit = 0;
        stepCount  = 0;

        fd = $fopen(stepFile, "r");
        if (fd == 0) stopWithFailure("Could not open the step file");
        while ($fgets(line, fd) != 0) begin
            if (isStep(line)) stepCount++;
        end
        $fclose(fd);
        cycleLimit = stepCount + 20;   // Four reset cycles fit in the margin

        fd = $fopen(stepFile, "r");
        repeat (4) @(posedge clk);
        while ($fgets(line, fd) != 0) begin
            if (isStep(line)) begin
                @(negedge clk);
                fields = $sscanf(line, "%h %h %h %h %h %h %h %h",
                                 mask, op, data, fill, chkBus, expBus, chkOut, expOut);
                if (fields != 8) stopWithFailure("A line of the step file is malformed");
                reset   = mask[0];
                strobes = mask[27:1];
                opcode  = aluOpT'(op[4:0]);
                // Unused IR bits get random filler
                inPortData = fill[0] ? (data | ($urandom & 32'h0000_7FFF)) : data;
                #3;
                if (chkBus[0]) checkBus(busData, expBus);
                if (chkOut[0]) checkOutPort(outPortData, expOut);
            end
        end
        $fclose(fd);

        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: bench/stepsInput.txt
# Columns (hex): mask opcode inPortData fill checkBus expBus checkOut expOut
# Mask bits 0-13: reset read write BAout Rin Rout Gra Grb Grc MARin MDRin HIin LOin Yin
# Mask bits 14-27: Zin PCin IRin incPC InPortIn OutPortIn HIout LOout ZHighOut ZLowOut MDRout PCout InPortOut Cout
0040000 0 ff00ff00 0 0 00000000 0 00000000
4040400 0 00000075 0 1 ff00ff00 0 00000000
4040200 0 02800075 0 1 00000075 0 00000000
4040404 0 00000040 0 1 02800075 0 00000000
4008210 0 00000000 0 1 00000040 0 00000000
0000004 0 00000000 0 1 00000000 0 00000000
2024200 0 00000000 0 1 00000040 0 00000000
0808402 0 00000000 0 1 00000041 0 00000000
1010000 0 00000000 0 1 02800075 0 00000000
0002088 0 00000000 0 1 00000000 0 00000000
8004000 1 00000000 0 1 00000075 0 00000000
0800200 0 00000000 0 1 00000075 0 00000000
0000402 0 00000000 0 1 00000000 0 00000000
1000050 0 00000000 0 1 ff00ff00 0 00000000
0000060 0 00000000 0 1 ff00ff00 0 00000000
0000020 0 00000000 0 1 00000040 0 00000000
0040000 0 002a8000 1 0 00000000 0 00000000
4010000 0 00000000 0 0 00000000 0 00000000
00000a0 0 00000000 0 1 ff00ff00 0 00000000
0000160 0 00000000 0 1 00000040 0 00000000
0000120 0 00000000 0 1 ff00ff00 0 00000000
0040000 0 fffffff9 0 0 00000000 0 00000000
4042000 0 00000002 0 1 fffffff9 0 00000000
4000010 0 00000000 0 1 00000002 0 00000000
0004020 4 00000000 0 1 00000002 0 00000000
0400000 0 00000000 0 1 ffffffff 0 00000000
0804000 3 00000000 0 1 fffffffd 0 00000000
0400000 0 00000000 0 1 00000000 0 00000000
0804000 1 00000000 0 1 00000015 0 00000000
0804000 2 00000000 0 1 0000000e 0 00000000
0804000 5 00000000 0 1 ffffffeb 0 00000000
0804000 6 00000000 0 1 001fffff 0 00000000
0804000 f 00000000 0 1 80000000 0 00000000
0804000 7 00000000 0 1 7fffffff 0 00000000
0804000 8 00000000 0 1 ffffffff 0 00000000
0804000 9 00000000 0 1 fffffff3 0 00000000
0804000 a 00000000 0 1 ffcfffff 0 00000000
0804000 b 00000000 0 1 ffcffff9 0 00000000
0804000 c 00000000 0 1 fffffff9 0 00000000
0804000 d 00000000 0 1 00000007 0 00000000
0804000 e 00000000 0 1 fffffffe 0 00000000
0804000 4 00000000 0 1 00000000 0 00000000
0800000 0 00000000 0 1 ffffffff 0 00000000
0400000 0 00000000 0 1 fffffff9 0 00000000
0400800 0 00000000 0 1 fffffff9 0 00000000
0801000 0 00000000 0 1 ffffffff 0 00000000
0100000 0 00000000 0 1 fffffff9 0 00000000
0280000 0 00000000 0 1 ffffffff 0 00000000
0000000 0 00000000 0 1 00000000 1 ffffffff
0000001 0 00000000 0 1 00000000 0 00000000
2000000 0 00000000 0 1 00000000 1 00000000
0040000 0 00000075 0 0 00000000 0 00000000
4000200 0 00000000 0 1 00000075 0 00000000
0000402 0 00000000 0 1 00000000 0 00000000
1000000 0 00000000 0 1 ff00ff00 0 00000000

// File: list.f
verilog/cpuPkg.sv
verilog/regFile.sv
verilog/alu.sv
verilog/memoryUnit.sv
verilog/specialRegs.sv
verilog/busUnit.sv
verilog/datapath.sv
bench/datapathTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module datapathTb -f list.f -o simDatapath
./obj_dir/simDatapath > sim.log 2>&1 || true
cat sim.log

if grep -q "=== PASS ===" sim.log; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed"
exit 1
